// ==== oramPkg.sv ====
`default_nettype none

package oramPkg;

    // ====================
    // Program address and leaf geometry
    // ====================
    localparam int OramU = 16;                  // Program address width
    localparam int OramL = 10;                  // Leaf label width

    // One position map entry is {written, leaf}
    localparam int EntryWidth = OramL + 1;

    // ====================
    // On-chip position map region
    // ====================
    localparam logic [OramU-1:0] PosMapStart = 16'hFF00;
    localparam int LogPosMapEntries = 8;        // 256 entries above PosMapStart

endpackage

`default_nettype wire

// ==== plbPkg.sv ====
`default_nettype none

package plbPkg;

    // ====================
    // Command codes
    // ====================
    localparam logic [1:0] CmdUpdate     = 2'd0;
    localparam logic [1:0] CmdRead       = 2'd1;
    localparam logic [1:0] CmdRefill     = 2'd2;
    localparam logic [1:0] CmdInitRefill = 2'd3;

    // ====================
    // PLB geometry
    // ====================
    localparam int LogLeafInBlock = 2;          // 4 entries per block
    localparam int LeafWidth = (1 << LogLeafInBlock) * oramPkg::EntryWidth;
    localparam int LogPlbSets = 4;              // 16 direct-mapped lines

    // ====================
    // Leaf LFSR
    // ====================
    localparam logic [15:0] LfsrSeed = 16'hACE1;
    localparam logic [15:0] LfsrTaps = 16'hB400;   // Galois feedback mask

    // A block is moved around as one raw word, but looked up per entry.
    // Entry i sits at bits [i*EntryWidth +: EntryWidth] with the written bit on top
    typedef union packed {
        logic [LeafWidth-1:0] raw;
        logic [(1 << LogLeafInBlock)-1:0][oramPkg::EntryWidth-1:0] entries;
    } plbBlock_t;

endpackage

`default_nettype wire

// ==== leafLfsr.sv ====
`default_nettype none

module leafLfsr (
    input  wire logic                       Clock,
    input  wire logic                       reset,
    input  wire logic                       advance,
    output logic [oramPkg::OramL-1:0]       leaf
);
    import oramPkg::*;
    import plbPkg::*;

    logic [15:0] state;

    // Right-shifting Galois form that folds in the taps when bit 0 falls out
    always_ff @(posedge Clock) begin
        if (reset) begin
            state <= LfsrSeed;
        end else if (advance) begin
            state <= (state >> 1) ^ (state[0] ? LfsrTaps : 16'h0000);
        end
    end

    assign leaf = state[OramL-1:0];

endmodule

`default_nettype wire

// ==== onChipPosMap.sv ====
`default_nettype none

module onChipPosMap (
    input  wire logic                                   Clock,
    input  wire logic                                   reset,
    input  wire logic                                   enable,
    input  wire logic                                   write,
    input  wire logic [oramPkg::LogPosMapEntries-1:0]   addr,
    input  wire logic [oramPkg::OramL-1:0]              leafIn,
    output logic [oramPkg::EntryWidth-1:0]              entry
);
    import oramPkg::*;

    // Leaf storage
    logic [OramL-1:0] leafRam [1 << LogPosMapEntries];

    // One written flag per entry
    logic [(1 << LogPosMapEntries)-1:0] writtenFlags;

    // ====================
    // Flags
    // ====================
    always_ff @(posedge Clock) begin
        if (reset) begin
            writtenFlags <= '0;
        end else if (enable && write) begin
            writtenFlags[addr] <= 1'b1;
        end
    end

    // ====================
    // RAM with read-before-write
    // ====================
    always_ff @(posedge Clock) begin
        if (enable) begin
            entry <= {writtenFlags[addr], leafRam[addr]};   // Old value on an update
            if (write) begin
                leafRam[addr] <= leafIn;
            end
        end
    end

endmodule

`default_nettype wire

// ==== plbCache.sv ====
`default_nettype none

module plbCache (
    input  wire logic                           Clock,
    input  wire logic                           reset,
    input  wire logic                           enable,
    input  wire logic [1:0]                     cmd,
    input  wire logic [oramPkg::OramU-1:0]      addr,
    input  wire logic [oramPkg::OramL-1:0]      leafIn,
    input  wire plbPkg::plbBlock_t              blockIn,
    output logic                                valid,
    output logic                                hit,
    output logic [oramPkg::EntryWidth-1:0]      entry,
    output logic                                evict,
    output logic [oramPkg::OramU-1:0]           evictAddr,
    output plbPkg::plbBlock_t                   evictBlock
);
    import oramPkg::*;
    import plbPkg::*;

    // Address splits into tag, index and offset
    logic [OramU-LogLeafInBlock-LogPlbSets-1:0] tag;
    logic [LogPlbSets-1:0]                      index;
    logic [LogLeafInBlock-1:0]                  offset;
    logic                                       lineHit;

    // Line state
    logic [(1 << LogPlbSets)-1:0]               occupied;
    logic [OramU-LogLeafInBlock-LogPlbSets-1:0] tags [1 << LogPlbSets];
    plbBlock_t                                  blocks [1 << LogPlbSets];

    assign tag    = addr[OramU-1:LogLeafInBlock+LogPlbSets];
    assign index  = addr[LogLeafInBlock +: LogPlbSets];
    assign offset = addr[LogLeafInBlock-1:0];

    assign lineHit = occupied[index] && (tags[index] == tag);

    // ====================
    // Control state
    // ====================
    always_ff @(posedge Clock) begin
        if (reset) begin
            valid    <= 1'b0;
            occupied <= '0;
        end else begin
            valid <= enable;                            // Fixed one-cycle latency
            if (enable && cmd == CmdRefill) begin
                occupied[index] <= 1'b1;
            end
        end
    end

    // ====================
    // Lookup, update, refill
    // ====================
    always_ff @(posedge Clock) begin
        if (enable) begin
            hit   <= lineHit;
            entry <= blocks[index].entries[offset];
            evict <= 1'b0;

            // Victim info is the line as it stood before this access
            evictAddr  <= {tags[index], index, {LogLeafInBlock{1'b0}}};
            evictBlock <= blocks[index];

            case (cmd)
                CmdUpdate: begin
                    if (lineHit) begin
                        blocks[index].entries[offset] <= {1'b1, leafIn};
                    end
                end
                CmdRefill: begin
                    evict         <= occupied[index];     // No dirty tracking
                    tags[index]   <= tag;
                    blocks[index] <= blockIn;
                end
                default: begin
                    // Read only looks
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== posMapControl.sv ====
`default_nettype none

module posMapControl (
    input  wire logic                                   Clock,
    input  wire logic                                   reset,
    input  wire logic                                   CmdValid,
    output logic                                        CmdReady,
    input  wire logic [1:0]                             Cmd,
    input  wire logic [oramPkg::OramU-1:0]              AddrIn,
    input  wire logic                                   DInValid,
    input  wire plbPkg::plbBlock_t                      DIn,
    input  wire logic                                   OutReady,
    output logic                                        Valid,
    output logic                                        Hit,
    output logic                                        UnInit,
    output logic [oramPkg::OramL-1:0]                   OldLeafOut,
    output logic [oramPkg::OramL-1:0]                   NewLeafOut,
    output logic                                        Evict,
    output logic [oramPkg::OramU-1:0]                   AddrOut,
    output logic                                        EvictDataOutValid,
    output plbPkg::plbBlock_t                           EvictDataOut,
    output logic                                        mapEnable,
    output logic                                        mapWrite,
    output logic [oramPkg::LogPosMapEntries-1:0]        mapAddr,
    input  wire logic [oramPkg::EntryWidth-1:0]         mapEntry,
    output logic                                        plbEnable,
    output logic [1:0]                                  plbCmd,
    output logic [oramPkg::OramU-1:0]                   plbAddr,
    output plbPkg::plbBlock_t                           plbBlockIn,
    input  wire logic                                   plbValid,
    input  wire logic                                   plbHit,
    input  wire logic [oramPkg::EntryWidth-1:0]         plbEntry,
    input  wire logic                                   plbEvict,
    input  wire logic [oramPkg::OramU-1:0]              plbEvictAddr,
    input  wire plbPkg::plbBlock_t                      plbEvictBlock,
    input  wire logic [oramPkg::OramL-1:0]              freshLeaf,
    output logic                                        lfsrAdvance,
    output logic [oramPkg::OramL-1:0]                   writeLeaf
);
    import oramPkg::*;
    import plbPkg::*;

    logic                  busy;          // High from command accept until the response is taken
    logic                  issuing;       // Waiting to strobe a store
    logic                  pending;       // Store strobed and result due
    logic [1:0]            cmdReg;
    logic [OramU-1:0]      addrReg;
    logic                  useMap;
    logic                  cmdFire;
    logic                  go;
    logic                  load;
    logic                  isRefill;
    logic                  resHit;
    logic                  resEvict;
    logic [EntryWidth-1:0] resEntry;
    logic [OramL-1:0]      oldLeaf;
    logic [OramU-1:0]      mapOffset;

    assign CmdReady = !busy;
    assign cmdFire  = CmdValid && CmdReady;
    assign isRefill = (cmdReg == CmdRefill) || (cmdReg == CmdInitRefill);

    // A refill holds here until its data beat shows up
    assign go = issuing && ((cmdReg != CmdRefill) || DInValid);

    // ====================
    // Store strobes
    // ====================
    assign mapEnable = go && useMap;
    assign mapWrite  = mapEnable && (cmdReg == CmdUpdate);
    assign mapOffset = addrReg - PosMapStart;
    assign mapAddr   = mapOffset[LogPosMapEntries-1:0];

    assign plbEnable  = go && !useMap;
    assign plbCmd     = (cmdReg == CmdInitRefill) ? CmdRefill : cmdReg;
    assign plbAddr    = isRefill ? {addrReg[OramU-1:LogLeafInBlock], {LogLeafInBlock{1'b0}}}
                                 : addrReg;
    assign plbBlockIn = (cmdReg == CmdRefill) ? DIn : plbBlock_t'('0);  // Init refill is all unwritten

    assign writeLeaf = freshLeaf;

    // ====================
    // Result merge
    // ====================
    assign load     = pending && (useMap || plbValid);
    assign resHit   = useMap || plbHit;             // The map always hits
    assign resEvict = !useMap && plbEvict;
    assign resEntry = useMap ? mapEntry : plbEntry;
    assign oldLeaf  = resHit ? resEntry[OramL-1:0] : '0;

    // The fresh leaf is consumed only by an update that actually wrote
    assign lfsrAdvance = load && resHit && (cmdReg == CmdUpdate);

    always_ff @(posedge Clock) begin
        if (reset) begin
            busy              <= 1'b0;
            issuing           <= 1'b0;
            pending           <= 1'b0;
            Valid             <= 1'b0;
            EvictDataOutValid <= 1'b0;
        end else begin
            if (cmdFire) begin
                busy    <= 1'b1;
                issuing <= 1'b1;
            end
            if (go) begin
                issuing <= 1'b0;
                pending <= 1'b1;
            end
            if (load) begin
                pending           <= 1'b0;
                Valid             <= 1'b1;
                EvictDataOutValid <= resEvict;
            end else if (Valid && OutReady) begin
                Valid             <= 1'b0;
                EvictDataOutValid <= 1'b0;
                busy              <= 1'b0;     // Next command can go in
            end
        end
    end

    // Command and response payload
    always_ff @(posedge Clock) begin
        if (cmdFire) begin
            cmdReg  <= Cmd;
            addrReg <= AddrIn;
            useMap  <= (AddrIn >= PosMapStart) && ((Cmd == CmdUpdate) || (Cmd == CmdRead));
        end
        if (load) begin
            Hit          <= resHit;
            UnInit       <= resHit && !resEntry[OramL];
            OldLeafOut   <= oldLeaf;
            NewLeafOut   <= lfsrAdvance ? freshLeaf : oldLeaf;
            Evict        <= resEvict;
            AddrOut      <= resEvict ? plbEvictAddr : addrReg;
            EvictDataOut <= plbEvictBlock;
        end
    end

endmodule

`default_nettype wire

// ==== posMapPlb.sv ====
`default_nettype none

module posMapPlb (
    input  wire logic                           Clock,
    input  wire logic                           reset,
    input  wire logic                           CmdValid,
    output logic                                CmdReady,
    input  wire logic [1:0]                     Cmd,
    input  wire logic [oramPkg::OramU-1:0]      AddrIn,
    input  wire logic                           DInValid,
    input  wire plbPkg::plbBlock_t              DIn,
    input  wire logic                           OutReady,
    output logic                                Valid,
    output logic                                Hit,
    output logic                                UnInit,
    output logic [oramPkg::OramL-1:0]           OldLeafOut,
    output logic [oramPkg::OramL-1:0]           NewLeafOut,
    output logic                                Evict,
    output logic [oramPkg::OramU-1:0]           AddrOut,
    output logic                                EvictDataOutValid,
    output plbPkg::plbBlock_t                   EvictDataOut
);
    import oramPkg::*;
    import plbPkg::*;

    // Controller to on-chip map
    logic                        mapEnable;
    logic                        mapWrite;
    logic [LogPosMapEntries-1:0] mapAddr;
    logic [EntryWidth-1:0]       mapEntry;

    // Controller to PLB
    logic                        plbEnable;
    logic [1:0]                  plbCmd;
    logic [OramU-1:0]            plbAddr;
    plbBlock_t                   plbBlockIn;
    logic                        plbValid;
    logic                        plbHit;
    logic [EntryWidth-1:0]       plbEntry;
    logic                        plbEvict;
    logic [OramU-1:0]            plbEvictAddr;
    plbBlock_t                   plbEvictBlock;

    // Leaf source
    logic [OramL-1:0]            freshLeaf;
    logic [OramL-1:0]            writeLeaf;
    logic                        lfsrAdvance;

    posMapControl control_inst (
        .Clock(Clock), .reset(reset),
        .CmdValid(CmdValid), .CmdReady(CmdReady), .Cmd(Cmd), .AddrIn(AddrIn),
        .DInValid(DInValid), .DIn(DIn),
        .OutReady(OutReady), .Valid(Valid), .Hit(Hit), .UnInit(UnInit),
        .OldLeafOut(OldLeafOut), .NewLeafOut(NewLeafOut), .Evict(Evict), .AddrOut(AddrOut),
        .EvictDataOutValid(EvictDataOutValid), .EvictDataOut(EvictDataOut),
        .mapEnable(mapEnable), .mapWrite(mapWrite), .mapAddr(mapAddr), .mapEntry(mapEntry),
        .plbEnable(plbEnable), .plbCmd(plbCmd), .plbAddr(plbAddr), .plbBlockIn(plbBlockIn),
        .plbValid(plbValid), .plbHit(plbHit), .plbEntry(plbEntry), .plbEvict(plbEvict),
        .plbEvictAddr(plbEvictAddr), .plbEvictBlock(plbEvictBlock),
        .freshLeaf(freshLeaf), .lfsrAdvance(lfsrAdvance), .writeLeaf(writeLeaf)
    );

    onChipPosMap posMap_inst (
        .Clock(Clock), .reset(reset), .enable(mapEnable), .write(mapWrite),
        .addr(mapAddr), .leafIn(writeLeaf), .entry(mapEntry)
    );

    plbCache plb_inst (
        .Clock(Clock), .reset(reset), .enable(plbEnable), .cmd(plbCmd),
        .addr(plbAddr), .leafIn(writeLeaf), .blockIn(plbBlockIn),
        .valid(plbValid), .hit(plbHit), .entry(plbEntry),
        .evict(plbEvict), .evictAddr(plbEvictAddr), .evictBlock(plbEvictBlock)
    );

    leafLfsr lfsr_inst (
        .Clock(Clock), .reset(reset), .advance(lfsrAdvance), .leaf(freshLeaf)
    );

endmodule

`default_nettype wire

// ==== posMapPlbTb.sv ====
`default_nettype none

module posMapPlbTb;
    timeunit 1ns;
    timeprecision 100ps;

    import oramPkg::*;
    import plbPkg::*;

    localparam int NumRows = 21;
    localparam int TimeoutCycles = 50;
    localparam logic [31:0] RandomSeed = 32'hd634_9bcb;

    // Raw blocks listed from entry 3 down to entry 0 as {written, leaf}
    localparam logic [LeafWidth-1:0] BlockA = {11'h744, 11'h233, 11'h522, 11'h411};
    localparam logic [LeafWidth-1:0] BlockB = {11'h6AA, 11'h555, 11'h7FF, 11'h0AB};

    typedef struct {
        string            name;
        logic [1:0]       cmd;
        logic [OramU-1:0] addr;
        plbBlock_t        din;
        logic             hit;
        logic             unInit;
        logic             evict;
    } testRow_t;

    logic             Clock, reset, CmdValid, CmdReady, DInValid, OutReady;
    logic [1:0]       Cmd;
    logic [OramU-1:0] AddrIn, AddrOut;
    plbBlock_t        DIn, EvictDataOut;
    logic             Valid, Hit, UnInit, Evict, EvictDataOutValid;
    logic [OramL-1:0] OldLeafOut, NewLeafOut;

    int errorCount = 0;
    int passCount = 0;
    int failCount = 0;
    bit timedOut = 1'b0;

    // Reference model state
    bit [(1 << LogPosMapEntries)-1:0]           mapWritten;
    logic [OramL-1:0]                           mapLeaf [1 << LogPosMapEntries];
    bit [(1 << LogPlbSets)-1:0]                 plbOcc;
    logic [OramU-LogLeafInBlock-LogPlbSets-1:0] plbTag [1 << LogPlbSets];
    plbBlock_t                                  plbBlk [1 << LogPlbSets];
    logic [15:0]                                lfsrState = LfsrSeed;

    // ====================
    // Stimulus table
    // ====================
    testRow_t rows [NumRows] = '{
        '{"mapReadUninit",    CmdRead,       16'hFF10, '0,     1'b1, 1'b1, 1'b0},
        '{"mapUpdateUninit",  CmdUpdate,     16'hFF10, '0,     1'b1, 1'b1, 1'b0},
        '{"mapReadWritten",   CmdRead,       16'hFF10, '0,     1'b1, 1'b0, 1'b0},
        '{"mapUpdateWritten", CmdUpdate,     16'hFF10, '0,     1'b1, 1'b0, 1'b0},
        '{"mapReadTop",       CmdRead,       16'hFFFF, '0,     1'b1, 1'b1, 1'b0},
        '{"plbReadMiss",      CmdRead,       16'h0104, '0,     1'b0, 1'b0, 1'b0},
        '{"plbUpdateMiss",    CmdUpdate,     16'h0104, '0,     1'b0, 1'b0, 1'b0},
        '{"plbRefillA",       CmdRefill,     16'h0106, BlockA, 1'b0, 1'b0, 1'b0},
        '{"plbReadA0",        CmdRead,       16'h0104, '0,     1'b1, 1'b0, 1'b0},
        '{"plbReadA1",        CmdRead,       16'h0105, '0,     1'b1, 1'b0, 1'b0},
        '{"plbReadA2",        CmdRead,       16'h0106, '0,     1'b1, 1'b1, 1'b0},
        '{"plbReadA3",        CmdRead,       16'h0107, '0,     1'b1, 1'b0, 1'b0},
        '{"plbUpdateA1",      CmdUpdate,     16'h0105, '0,     1'b1, 1'b0, 1'b0},
        '{"plbReReadA1",      CmdRead,       16'h0105, '0,     1'b1, 1'b0, 1'b0},
        '{"plbInitRefill",    CmdInitRefill, 16'h020B, '0,     1'b0, 1'b0, 1'b0},
        '{"plbReadInit",      CmdRead,       16'h020A, '0,     1'b1, 1'b1, 1'b0},
        '{"plbUpdateInit",    CmdUpdate,     16'h0209, '0,     1'b1, 1'b1, 1'b0},
        '{"plbRefillEvictA",  CmdRefill,     16'h0444, BlockB, 1'b0, 1'b0, 1'b1},
        '{"plbReadB3",        CmdRead,       16'h0447, '0,     1'b1, 1'b0, 1'b0},
        '{"plbReadOldTag",    CmdRead,       16'h0105, '0,     1'b0, 1'b0, 1'b0},
        '{"plbInitEvict",     CmdInitRefill, 16'h0A08, '0,     1'b0, 1'b0, 1'b1}
    };

    posMapPlb posMapPlb_inst (
        .Clock(Clock), .reset(reset), .CmdValid(CmdValid), .CmdReady(CmdReady),
        .Cmd(Cmd), .AddrIn(AddrIn), .DInValid(DInValid), .DIn(DIn),
        .OutReady(OutReady), .Valid(Valid), .Hit(Hit), .UnInit(UnInit),
        .OldLeafOut(OldLeafOut), .NewLeafOut(NewLeafOut), .Evict(Evict), .AddrOut(AddrOut),
        .EvictDataOutValid(EvictDataOutValid), .EvictDataOut(EvictDataOut)
    );

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    // ====================
    // Compare tasks
    // ====================
    task automatic checkLeaf(input string what, input logic [OramL-1:0] exp,
            input logic [OramL-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", what, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkFlag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", what, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkAddr(input string what, input logic [OramU-1:0] exp,
            input logic [OramU-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", what, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkBlock(input string what, input plbBlock_t exp, input plbBlock_t act);
        if (act.raw !== exp.raw) begin
            $display("CHECK FAILED %s: expected %h, actual %h", what, exp.raw, act.raw);
            errorCount++;
        end
    endtask

    // Everything that must hold still under back-pressure
    function automatic logic [4+2*OramL+OramU+LeafWidth:0] responseWord();
        return {Valid, Hit, UnInit, Evict, EvictDataOutValid,
                OldLeafOut, NewLeafOut, AddrOut, EvictDataOut.raw};
    endfunction

    // ====================
    // Reference model
    // ====================
    task automatic predict(input testRow_t row, output logic [OramL-1:0] expOld,
            output logic [OramL-1:0] expNew, output logic [OramU-1:0] expAddr,
            output plbBlock_t expBlock, output bit oldKnown, output bit newKnown);
        logic [OramU-1:0]                           mapOffset;
        logic [LogPosMapEntries-1:0]                mapIdx;
        logic [LogPlbSets-1:0]                      line;
        logic [OramU-LogLeafInBlock-LogPlbSets-1:0] tag;
        logic [LogLeafInBlock-1:0]                  slot;
        bit                                         onMap;
        bit                                         lineHit;
        mapOffset = row.addr - PosMapStart;
        mapIdx = mapOffset[LogPosMapEntries-1:0];
        line = row.addr[LogLeafInBlock +: LogPlbSets];
        tag = row.addr[OramU-1:LogLeafInBlock+LogPlbSets];
        slot = row.addr[LogLeafInBlock-1:0];
        onMap = (row.addr >= PosMapStart);
        lineHit = plbOcc[line] && (plbTag[line] == tag);
        expAddr = row.addr;
        expBlock = plbBlk[line];
        expOld = '0;
        expNew = '0;
        oldKnown = 1'b0;
        newKnown = 1'b0;
        if (row.cmd == CmdRefill || row.cmd == CmdInitRefill) begin
            if (plbOcc[line]) begin
                expAddr = {plbTag[line], line, {LogLeafInBlock{1'b0}}};   // Victim block base
            end
            plbOcc[line] = 1'b1;
            plbTag[line] = tag;
            plbBlk[line] = (row.cmd == CmdRefill) ? row.din : plbBlock_t'('0);
        end else begin
            if (onMap) begin
                oldKnown = mapWritten[mapIdx];      // Unwritten RAM word is undefined
                expOld = mapLeaf[mapIdx];
            end else begin
                oldKnown = 1'b1;
                expOld = lineHit ? plbBlk[line].entries[slot][OramL-1:0] : '0;
            end
            expNew = expOld;
            newKnown = oldKnown;
            if (row.cmd == CmdUpdate && (onMap || lineHit)) begin
                expNew = lfsrState[OramL-1:0];
                newKnown = 1'b1;
                if (onMap) begin
                    mapLeaf[mapIdx] = expNew;
                    mapWritten[mapIdx] = 1'b1;
                end else begin
                    plbBlk[line].entries[slot] = {1'b1, expNew};
                end
                lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? LfsrTaps : 16'h0000);
            end
        end
    endtask

    // ====================
    // Sequencing
    // ====================
    task automatic waitSignal(input bit forValid, input string name);
        int cycles;
        cycles = 0;
        do begin
            @(negedge Clock);
            cycles++;
        end while ((forValid ? !Valid : !CmdReady) && cycles < TimeoutCycles);
        if (forValid ? !Valid : !CmdReady) begin
            $display("%s: gave up after %0d cycles waiting for %s", name, TimeoutCycles,
                     forValid ? "Valid" : "CmdReady");
            timedOut = 1'b1;
        end
    endtask

    task automatic runRow(input testRow_t row);
        logic [OramL-1:0]                  expOld;
        logic [OramL-1:0]                  expNew;
        logic [OramU-1:0]                  expAddr;
        plbBlock_t                         expBlock;
        bit                                oldKnown;
        bit                                newKnown;
        logic [4+2*OramL+OramU+LeafWidth:0] held;
        int                                stall;
        int                                errorsBefore;
        errorsBefore = errorCount;
        predict(row, expOld, expNew, expAddr, expBlock, oldKnown, newKnown);
        waitSignal(1'b0, row.name);
        if (!timedOut) begin
            @(posedge Clock);
            CmdValid <= 1'b1;
            Cmd <= row.cmd;
            AddrIn <= row.addr;
            DIn <= row.din;
            @(posedge Clock);                      // Command transfers here
            CmdValid <= 1'b0;
            if (row.cmd == CmdRefill) begin
                repeat ($urandom_range(5, 0)) @(posedge Clock);
                DInValid <= 1'b1;
                @(posedge Clock);
                DInValid <= 1'b0;
            end
            waitSignal(1'b1, row.name);
        end
        if (!timedOut) begin
            checkFlag({row.name, " Hit"}, row.hit, Hit);
            checkFlag({row.name, " UnInit"}, row.unInit, UnInit);
            checkFlag({row.name, " Evict"}, row.evict, Evict);
            checkFlag({row.name, " EvictDataOutValid"}, row.evict, EvictDataOutValid);
            checkFlag({row.name, " CmdReady"}, 1'b0, CmdReady);
            checkAddr({row.name, " AddrOut"}, expAddr, AddrOut);
            if (oldKnown) checkLeaf({row.name, " OldLeafOut"}, expOld, OldLeafOut);
            if (newKnown) checkLeaf({row.name, " NewLeafOut"}, expNew, NewLeafOut);
            if (row.evict) checkBlock({row.name, " EvictDataOut"}, expBlock, EvictDataOut);

            // Hold off the consumer for a while
            held = responseWord();
            stall = $urandom_range(5, 0);
            repeat (stall) begin
                @(negedge Clock);
                checkFlag({row.name, " CmdReady"}, 1'b0, CmdReady);
                if (responseWord() !== held) begin
                    $display("%s: response changed while OutReady was low", row.name);
                    errorCount++;
                end
            end
            @(posedge Clock);
            OutReady <= 1'b1;
            @(posedge Clock);                      // Response transfers here
            OutReady <= 1'b0;
        end
        if (!timedOut && errorCount == errorsBefore) begin
            $display("PASS %s", row.name);
            passCount++;
        end else begin
            $display("FAIL %s", row.name);
            failCount++;
        end
    endtask

    initial begin
        void'($urandom(RandomSeed));
        reset = 1'b1;
        CmdValid = 1'b0;
        Cmd = CmdRead;
        AddrIn = '0;
        DInValid = 1'b0;
        DIn = '0;
        OutReady = 1'b0;
        repeat (4) @(posedge Clock);
        reset <= 1'b0;

        for (int i = 0; i < NumRows && !timedOut; i++) begin
            runRow(rows[i]);
        end

        $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
                 passCount + failCount, passCount, failCount, errorCount);
        if (errorCount == 0 && failCount == 0 && !timedOut) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
oramPkg.sv
plbPkg.sv
leafLfsr.sv
onChipPosMap.sv
plbCache.sv
posMapControl.sv
posMapPlb.sv
posMapPlbTb.sv

// ==== Makefile ====
# Verilator build and run for the position map PLB testbench

VERILATOR ?= verilator
TOP       ?= posMapPlbTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
